/* sources.f */
+incdir+include
logic/coherence_pkg.sv
logic/bus_pkg.sv
logic/l1_dcache.sv
logic/bus_controller.sv
logic/coherent_cache_pair.sv
verification/tb_clock_gen.sv
verification/tb_l2_model.sv
verification/tb_cache_coherency.sv

/* Makefile */
# Verilator simulation of the coherent cache pair

VERILATOR ?= verilator
TOP       ?= tb_cache_coherency
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# Build, then run; a failing run exits non-zero
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_cache_coherency.sv */
// Coherent cache pair testbench
`timescale 1ns/1ps
`default_nettype none
`include "coherence_macros.svh"

module tb_cache_coherency;

    localparam int L2_LATENCY    = 3;
    localparam int NUM_RANDOM    = 40;
    localparam int DIRECTED_OPS  = 13;           // Core accesses in the directed tests
    localparam int SNOOP_CYCLES  = 2;
    localparam int MARGIN_CYCLES = 6;            // Grant, complete, core hand-off
    // Any access may need a write-back plus a fetch
    localparam int TIMEOUT_CYCLES = (DIRECTED_OPS + NUM_RANDOM) * 2
                                    * (SNOOP_CYCLES + L2_LATENCY + MARGIN_CYCLES) + 20;

    localparam logic [`ADDR_W-1:0] ADDR_A = 32'h0000_0100;   // Set 0
    localparam logic [`ADDR_W-1:0] ADDR_B = 32'h0000_0204;   // Set 1
    localparam logic [`ADDR_W-1:0] ADDR_C = 32'h0000_0308;   // Set 2
    localparam logic [`ADDR_W-1:0] ADDR_D = 32'h0000_0408;   // Set 2, other tag
    localparam logic [`WORD_W-1:0] WORD_A = 32'h1111_A0A0;
    localparam logic [`WORD_W-1:0] WORD_B = 32'h2222_B0B0;
    localparam logic [`WORD_W-1:0] WORD_C = 32'h3333_C0C0;

    logic                              clk;
    logic                              reset;
    logic [`NUM_CPUS-1:0]              ren;
    logic [`NUM_CPUS-1:0]              wen;
    logic [`NUM_CPUS-1:0][`ADDR_W-1:0] addr;
    logic [`NUM_CPUS-1:0][`WORD_W-1:0] wdata;
    logic [`NUM_CPUS-1:0][`WORD_W-1:0] rdata;
    logic [`NUM_CPUS-1:0]              busy;
    logic                              l2_ren;
    logic                              l2_wen;
    logic [`ADDR_W-1:0]                l2_addr;
    logic [`WORD_W-1:0]                l2_store;
    logic [`WORD_W-1:0]                l2_load;
    bus_pkg::l2_state_t                l2_state;
    int                                l2_reads;
    int                                l2_writes;
    logic [`ADDR_W-1:0]                l2_rd_addr;
    logic [`ADDR_W-1:0]                l2_wr_addr;
    logic [`WORD_W-1:0]                l2_wr_data;
    integer                            seed;
    int                                cycles = 0;

    tb_clock_gen #(.PERIOD(10)) tb_clock_gen_inst (.clk(clk));

    tb_l2_model #(.LATENCY(L2_LATENCY)) tb_l2_model_inst (
        .clk(clk), .reset(reset), .ren(l2_ren), .wen(l2_wen), .addr(l2_addr),
        .store(l2_store), .load(l2_load), .state(l2_state),
        .read_count(l2_reads), .write_count(l2_writes), .last_read_addr(l2_rd_addr),
        .last_write_addr(l2_wr_addr), .last_write_data(l2_wr_data)
    );

    coherent_cache_pair coherent_cache_pair_inst (
        .CLK(clk), .reset(reset), .ren(ren), .wen(wen), .addr(addr), .wdata(wdata),
        .rdata(rdata), .busy(busy), .l2REN(l2_ren), .l2WEN(l2_wen), .l2addr(l2_addr),
        .l2store(l2_store), .l2load(l2_load), .l2state(l2_state)
    );

    // Run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: no finish after %0d cycles, a request never completed",
                     TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped by timeout");
        end
    end

    // Expected L2 word at an address nobody wrote
    function automatic logic [`WORD_W-1:0] l2_init_word(input logic [`ADDR_W-1:0] a);
        return {a[15:0], a[31:16]} ^ 32'hA5C3_5A3C;
    endfunction

    task automatic check_word(input string name, input logic [`WORD_W-1:0] exp,
                              input logic [`WORD_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_addr(input string name, input logic [`ADDR_W-1:0] exp,
                              input logic [`ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic check_l2_state(input string name, input bus_pkg::l2_state_t exp,
                                  input bus_pkg::l2_state_t act);
        if (act !== exp) begin
            $display("ERR %s expected %s actual %s", name, exp.name(), act.name());
            $display("ERRORS FOUND");
            $fatal(1, "L2 state mismatch");
        end
    endtask

    // One core request is held until busy is seen low
    task automatic core_access(input int core, input logic write,
                               input logic [`ADDR_W-1:0] a, input logic [`WORD_W-1:0] d,
                               output logic [`WORD_W-1:0] q);
        @(posedge clk);
        ren[core]   <= !write;
        wen[core]   <= write;
        addr[core]  <= a;
        wdata[core] <= d;
        do begin
            @(negedge clk);
        end while (busy[core]);                  // Done at the coming edge
        q = rdata[core];
        @(posedge clk);
        ren[core] <= 1'b0;
        wen[core] <= 1'b0;
        @(negedge clk);
    endtask

    task automatic cold_read();
        logic [`WORD_W-1:0] q;
        repeat (L2_LATENCY + 2) @(negedge clk);  // Long enough for a stray L2 access
        check_count("reset_busy", 0, int'(busy));
        check_count("reset_l2_reads", 0, l2_reads);
        check_count("reset_l2_writes", 0, l2_writes);
        check_l2_state("reset_l2_state", bus_pkg::L2_FREE, l2_state);
        core_access(0, 1'b0, ADDR_A, '0, q);
        check_word("cold_read_data", l2_init_word(ADDR_A), q);
        check_count("cold_read_l2_reads", 1, l2_reads);
        core_access(0, 1'b0, ADDR_A, '0, q);     // Now a hit
        check_word("read_hit_data", l2_init_word(ADDR_A), q);
        check_count("read_hit_l2_reads", 1, l2_reads);
    endtask

    task automatic silent_upgrade();
        logic [`WORD_W-1:0] q;
        int                 rd0;
        int                 wr0;
        rd0 = l2_reads;
        wr0 = l2_writes;
        core_access(0, 1'b1, ADDR_A, WORD_A, q); // E to M without bus traffic
        core_access(0, 1'b0, ADDR_A, '0, q);
        check_word("upgrade_readback", WORD_A, q);
        check_count("upgrade_l2_reads", rd0, l2_reads);
        check_count("upgrade_l2_writes", wr0, l2_writes);
    endtask

    task automatic modified_to_shared();
        logic [`WORD_W-1:0] q;
        int                 rd0;
        int                 wr0;
        rd0 = l2_reads;
        wr0 = l2_writes;
        core_access(1, 1'b0, ADDR_A, '0, q);     // Dirty snoop hit in core 0
        check_word("m2s_core1_data", WORD_A, q);
        check_count("m2s_l2_writes", wr0 + 1, l2_writes);
        check_addr("m2s_wb_addr", ADDR_A, l2_wr_addr);
        check_word("m2s_wb_data", WORD_A, l2_wr_data);
        check_count("m2s_l2_reads", rd0, l2_reads);
        core_access(0, 1'b0, ADDR_A, '0, q);
        check_word("m2s_core0_hit", WORD_A, q);
        check_count("m2s_hit_l2_reads", rd0, l2_reads);
        check_count("m2s_hit_l2_writes", wr0 + 1, l2_writes);
    endtask

    task automatic invalidation();
        logic [`WORD_W-1:0] q;
        int                 rd0;
        int                 wr0;
        core_access(0, 1'b0, ADDR_B, '0, q);
        core_access(1, 1'b0, ADDR_B, '0, q);     // Both SHARED now
        check_word("inv_shared_data", l2_init_word(ADDR_B), q);
        rd0 = l2_reads;
        wr0 = l2_writes;
        core_access(1, 1'b1, ADDR_B, WORD_B, q); // Upgrade kills core 0 copy
        core_access(0, 1'b0, ADDR_B, '0, q);
        check_word("inv_core0_data", WORD_B, q);
        check_count("inv_l2_writes", wr0 + 1, l2_writes);
        check_addr("inv_wb_addr", ADDR_B, l2_wr_addr);
        check_word("inv_wb_data", WORD_B, l2_wr_data);
        check_count("inv_l2_reads", rd0, l2_reads);
    endtask

    task automatic eviction();
        logic [`WORD_W-1:0] q;
        int                 rd0;
        int                 wr0;
        core_access(0, 1'b1, ADDR_C, WORD_C, q);
        rd0 = l2_reads;
        wr0 = l2_writes;
        core_access(0, 1'b0, ADDR_D, '0, q);     // C is the victim in the same set
        check_word("evict_read_d", l2_init_word(ADDR_D), q);
        check_count("evict_l2_writes", wr0 + 1, l2_writes);
        check_addr("evict_wb_addr", ADDR_C, l2_wr_addr);
        check_word("evict_wb_data", WORD_C, l2_wr_data);
        check_count("evict_l2_reads", rd0 + 1, l2_reads);
        check_addr("evict_fetch_addr", ADDR_D, l2_rd_addr);
        core_access(0, 1'b0, ADDR_C, '0, q);
        check_word("evict_reread_c", WORD_C, q);
        check_l2_state("evict_l2_idle", bus_pkg::L2_FREE, l2_state);
    endtask

    task automatic random_mix();
        logic [`ADDR_W-1:0] mix_addr [6];
        logic [`WORD_W-1:0] shadow [6];          // Last value written per address
        logic [`WORD_W-1:0] d;
        logic [`WORD_W-1:0] q;
        logic               write;
        int                 core;
        int                 slot;
        // Three tags in set 0, three in set 3
        mix_addr = '{32'h0001_0000, 32'h0002_0000, 32'h0003_0000,
                     32'h0001_000C, 32'h0002_000C, 32'h0003_000C};
        for (int i = 0; i < 6; i++) begin
            shadow[i] = l2_init_word(mix_addr[i]);
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            core  = $random(seed) & 1;
            slot  = $unsigned($random(seed)) % 6;
            write = ($random(seed) & 1) != 0;
            d     = $random(seed);
            core_access(core, write, mix_addr[slot], d, q);
            if (write)
                shadow[slot] = d;
            else
                check_word($sformatf("mix_read_%0d", n), shadow[slot], q);
        end
    endtask

    initial begin
        reset = 1'b1;
        ren   = '0;
        wen   = '0;
        addr  = '0;
        wdata = '0;
        seed  = 65910;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        cold_read();
        silent_upgrade();
        modified_to_shared();
        invalidation();
        eviction();
        random_mix();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/tb_l2_model.sv */
// Behavioral L2 memory
`timescale 1ns/1ps
`default_nettype none
`include "coherence_macros.svh"

module tb_l2_model #(
    parameter int LATENCY = 3                    // Busy cycles before the access cycle
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                ren,
    input  wire logic                wen,
    input  wire logic [`ADDR_W-1:0]  addr,
    input  wire logic [`WORD_W-1:0]  store,
    output logic      [`WORD_W-1:0]  load,
    output bus_pkg::l2_state_t       state,
    // Traffic seen so far
    output int                       read_count,
    output int                       write_count,
    output logic      [`ADDR_W-1:0]  last_read_addr,
    output logic      [`ADDR_W-1:0]  last_write_addr,
    output logic      [`WORD_W-1:0]  last_write_data
);

    logic [`WORD_W-1:0] mem [logic [`ADDR_W-1:0]];  // Holds written words only
    int                 wait_cnt;

    // Contents before any write use every address bit
    function automatic logic [`WORD_W-1:0] preload_word(input logic [`ADDR_W-1:0] a);
        return {a[15:0], a[31:16]} ^ 32'hA5C3_5A3C;
    endfunction

    assign state = !(ren || wen)         ? bus_pkg::L2_FREE
                 : (wait_cnt == LATENCY) ? bus_pkg::L2_ACCESS
                 :                         bus_pkg::L2_BUSY;

    // Access counting and word store
    always @(posedge clk) begin
        if (reset) begin
            wait_cnt    <= 0;
            read_count  <= 0;
            write_count <= 0;
        end else if (state == bus_pkg::L2_ACCESS) begin
            wait_cnt <= 0;                       // Ready for the next request
            if (wen) begin
                mem[addr]       = store;
                write_count     <= write_count + 1;
                last_write_addr <= addr;
                last_write_data <= store;
            end else begin
                read_count     <= read_count + 1;
                last_read_addr <= addr;
            end
        end else if (ren || wen) begin
            wait_cnt <= wait_cnt + 1;
        end
        // Read word tracks the address, which holds from the grant on
        load <= mem.exists(addr) ? mem[addr] : preload_word(addr);
    end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// Testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 10                    // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;        // Even duty cycle
    end

endmodule

`default_nettype wire

/* logic/coherent_cache_pair.sv */
// Two-core coherent cache top
`timescale 1ns/1ps
`default_nettype none
`include "coherence_macros.svh"

module coherent_cache_pair (
    input  wire logic                                CLK,
    input  wire logic                                reset,
    // Core ports
    input  wire logic  [`NUM_CPUS-1:0]               ren,
    input  wire logic  [`NUM_CPUS-1:0]               wen,
    input  wire logic  [`NUM_CPUS-1:0][`ADDR_W-1:0]  addr,
    input  wire logic  [`NUM_CPUS-1:0][`WORD_W-1:0]  wdata,
    output logic       [`NUM_CPUS-1:0][`WORD_W-1:0]  rdata,
    output logic       [`NUM_CPUS-1:0]               busy,
    // L2 port
    output logic                                     l2REN,
    output logic                                     l2WEN,
    output logic       [`ADDR_W-1:0]                 l2addr,
    output logic       [`WORD_W-1:0]                 l2store,
    input  wire logic  [`WORD_W-1:0]                 l2load,
    input  wire bus_pkg::l2_state_t                  l2state
);

    // Cache to controller
    logic [`NUM_CPUS-1:0]                dREN;
    logic [`NUM_CPUS-1:0]                dWEN;
    coherence_pkg::bus_op_t [`NUM_CPUS-1:0] bus_op;
    logic [`NUM_CPUS-1:0][`ADDR_W-1:0]   daddr;
    logic [`NUM_CPUS-1:0][`WORD_W-1:0]   dstore;
    logic [`NUM_CPUS-1:0]                dwait;
    logic [`NUM_CPUS-1:0][`WORD_W-1:0]   dload;
    logic [`NUM_CPUS-1:0]                ccexclusive;
    // Snoop wiring
    logic [`NUM_CPUS-1:0]                ccsnoop;
    logic [`NUM_CPUS-1:0][`ADDR_W-1:0]   ccsnoopaddr;
    logic [`NUM_CPUS-1:0]                ccinv;
    logic [`NUM_CPUS-1:0]                ccsnoophit;
    logic [`NUM_CPUS-1:0]                ccdirty;
    logic [`NUM_CPUS-1:0][`WORD_W-1:0]   ccdata;

    // One L1 per core
    for (genvar i = 0; i < `NUM_CPUS; i++) begin : g_core
        l1_dcache l1_dcache_inst (
            .CLK         (CLK),
            .reset       (reset),
            .ren         (ren[i]),
            .wen         (wen[i]),
            .addr        (addr[i]),
            .wdata       (wdata[i]),
            .rdata       (rdata[i]),
            .busy        (busy[i]),
            .dREN        (dREN[i]),
            .dWEN        (dWEN[i]),
            .bus_op      (bus_op[i]),
            .daddr       (daddr[i]),
            .dstore      (dstore[i]),
            .dwait       (dwait[i]),
            .dload       (dload[i]),
            .ccexclusive (ccexclusive[i]),
            .ccsnoop     (ccsnoop[i]),
            .ccsnoopaddr (ccsnoopaddr[i]),
            .ccinv       (ccinv[i]),
            .ccsnoophit  (ccsnoophit[i]),
            .ccdirty     (ccdirty[i]),
            .ccdata      (ccdata[i])
        );
    end

    bus_controller bus_controller_inst (
        .CLK         (CLK),
        .reset       (reset),
        .dREN        (dREN),
        .dWEN        (dWEN),
        .bus_op      (bus_op),
        .daddr       (daddr),
        .dstore      (dstore),
        .dwait       (dwait),
        .dload       (dload),
        .ccexclusive (ccexclusive),
        .ccsnoop     (ccsnoop),
        .ccsnoopaddr (ccsnoopaddr),
        .ccinv       (ccinv),
        .ccsnoophit  (ccsnoophit),
        .ccdirty     (ccdirty),
        .ccdata      (ccdata),
        .l2REN       (l2REN),
        .l2WEN       (l2WEN),
        .l2addr      (l2addr),
        .l2store     (l2store),
        .l2load      (l2load),
        .l2state     (l2state)
    );

endmodule

`default_nettype wire

/* logic/bus_controller.sv */
// Snooping bus controller
`timescale 1ns/1ps
`default_nettype none
`include "coherence_macros.svh"

module bus_controller (
    input  wire logic                                 CLK,
    input  wire logic                                 reset,
    // Cache requests
    input  wire logic   [`NUM_CPUS-1:0]               dREN,
    input  wire logic   [`NUM_CPUS-1:0]               dWEN,
    input  wire coherence_pkg::bus_op_t [`NUM_CPUS-1:0] bus_op,
    input  wire logic   [`NUM_CPUS-1:0][`ADDR_W-1:0]  daddr,
    input  wire logic   [`NUM_CPUS-1:0][`WORD_W-1:0]  dstore,
    output logic        [`NUM_CPUS-1:0]               dwait,
    output logic        [`NUM_CPUS-1:0][`WORD_W-1:0]  dload,
    output logic        [`NUM_CPUS-1:0]               ccexclusive,
    // Snoop broadcast
    output logic        [`NUM_CPUS-1:0]               ccsnoop,
    output logic        [`NUM_CPUS-1:0][`ADDR_W-1:0]  ccsnoopaddr,
    output logic        [`NUM_CPUS-1:0]               ccinv,
    input  wire logic   [`NUM_CPUS-1:0]               ccsnoophit,
    input  wire logic   [`NUM_CPUS-1:0]               ccdirty,
    input  wire logic   [`NUM_CPUS-1:0][`WORD_W-1:0]  ccdata,
    // L2 port
    output logic                                      l2REN,
    output logic                                      l2WEN,
    output logic        [`ADDR_W-1:0]                 l2addr,
    output logic        [`WORD_W-1:0]                 l2store,
    input  wire logic   [`WORD_W-1:0]                 l2load,
    input  wire bus_pkg::l2_state_t                   l2state
);

    bus_pkg::bus_state_t    state;
    coherence_pkg::bus_op_t op;                  // Granted request
    logic                   owner;               // Granted core
    logic                   other;               // Core to snoop
    logic                   prio;                // Round-robin favorite
    logic                   winner;
    logic                   snoop_second;        // Second SNOOP cycle
    logic                   excl;                // Fill may be EXCLUSIVE
    logic                   l2_done;
    logic [`NUM_CPUS-1:0]   req;
    logic [`ADDR_W-1:0]     xaddr;
    logic [`WORD_W-1:0]     xdata;               // Word moving on the bus

    assign req     = dREN | dWEN;
    assign winner  = req[prio] ? prio : !prio;   // Favorite first
    assign other   = !owner;
    assign l2_done = (l2state == bus_pkg::L2_ACCESS);

    // Transaction FSM
    always_ff @(posedge CLK) begin
        if (reset) begin
            state        <= bus_pkg::IDLE;
            prio         <= 1'b0;                // Core 0 first
            snoop_second <= 1'b0;
        end else begin
            case (state)
                bus_pkg::IDLE: begin
                    if (|req) begin
                        state <= bus_pkg::GRANT;
                        prio  <= !winner;        // Other core next time
                    end
                end
                bus_pkg::GRANT:
                    state <= (op == coherence_pkg::BUS_WB) ? bus_pkg::WRITE_L2 : bus_pkg::SNOOP;
                bus_pkg::SNOOP: begin
                    snoop_second <= !snoop_second;
                    if (snoop_second) begin
                        if (ccsnoophit[other] && ccdirty[other])
                            state <= bus_pkg::WRITE_L2;   // Supply and write back
                        else if (ccsnoophit[other])
                            state <= bus_pkg::TRANSFER;
                        else
                            state <= bus_pkg::READ_L2;
                    end
                end
                bus_pkg::TRANSFER:
                    state <= bus_pkg::COMPLETE;
                bus_pkg::READ_L2,
                bus_pkg::WRITE_L2: begin
                    if (l2_done)
                        state <= bus_pkg::COMPLETE;
                end
                default:
                    state <= bus_pkg::IDLE;      // COMPLETE
            endcase
        end
    end

    // Request capture and data path
    always_ff @(posedge CLK) begin
        if (state == bus_pkg::IDLE && |req) begin
            owner <= winner;
            op    <= bus_op[winner];
            xaddr <= daddr[winner];
            xdata <= dstore[winner];             // Used by BUS_WB only
        end
        if (state == bus_pkg::SNOOP && snoop_second) begin
            if (ccsnoophit[other])
                xdata <= ccdata[other];
            excl <= !ccsnoophit[other] || (op == coherence_pkg::BUS_RDX);
        end
        if (state == bus_pkg::READ_L2 && l2_done)
            xdata <= l2load;
    end

    // Per-cache outputs
    always_comb begin
        for (int i = 0; i < `NUM_CPUS; i++) begin
            // Waiting until its own COMPLETE cycle
            dwait[i]       = req[i] && !(state == bus_pkg::COMPLETE && owner == 1'(i));
            dload[i]       = xdata;
            ccexclusive[i] = excl;
            ccsnoop[i]     = (state == bus_pkg::SNOOP) && !snoop_second && (owner != 1'(i));
            ccsnoopaddr[i] = xaddr;
            ccinv[i]       = (state == bus_pkg::SNOOP) && (op == coherence_pkg::BUS_RDX)
                             && (owner != 1'(i));
        end
    end

    // L2 requests are held until L2_ACCESS
    assign l2REN   = (state == bus_pkg::READ_L2);
    assign l2WEN   = (state == bus_pkg::WRITE_L2);
    assign l2addr  = xaddr;
    assign l2store = xdata;

endmodule

`default_nettype wire

/* logic/l1_dcache.sv */
// Direct-mapped MESI L1 data cache
`timescale 1ns/1ps
`default_nettype none
`include "coherence_macros.svh"

module l1_dcache (
    input  wire logic                   CLK,
    input  wire logic                   reset,
    // Core side
    input  wire logic                   ren,
    input  wire logic                   wen,
    input  wire logic [`ADDR_W-1:0]     addr,
    input  wire logic [`WORD_W-1:0]     wdata,
    output logic      [`WORD_W-1:0]     rdata,
    output logic                        busy,
    // Requests to the bus controller
    output logic                        dREN,
    output logic                        dWEN,
    output coherence_pkg::bus_op_t      bus_op,
    output logic      [`ADDR_W-1:0]     daddr,
    output logic      [`WORD_W-1:0]     dstore,
    input  wire logic                   dwait,
    input  wire logic [`WORD_W-1:0]     dload,
    input  wire logic                   ccexclusive,
    // Snoop port
    input  wire logic                   ccsnoop,
    input  wire logic [`ADDR_W-1:0]     ccsnoopaddr,
    input  wire logic                   ccinv,
    output logic                        ccsnoophit,
    output logic                        ccdirty,
    output logic      [`WORD_W-1:0]     ccdata
);

    // Miss sequencing
    typedef enum logic [1:0] {
        C_IDLE,                                  // Serve hits, spot misses
        C_WB,                                    // Write back dirty victim
        C_FETCH                                  // BUS_RD or BUS_RDX
    } ctrl_state_t;

    logic [`TAG_W-1:0]          tag_mem   [`L1_SETS];
    logic [`WORD_W-1:0]         data_mem  [`L1_SETS];
    coherence_pkg::mesi_state_t state_mem [`L1_SETS];
    ctrl_state_t                cstate;

    logic [`INDEX_W-1:0] idx;
    logic [`TAG_W-1:0]   tag;
    logic [`INDEX_W-1:0] snp_idx;
    logic [`TAG_W-1:0]   snp_tag;
    logic                hit;
    logic                snp_hit;
    logic                snoop_block;
    logic                local_ok;
    logic                local_write;
    logic                start_miss;
    logic                victim_dirty;
    logic                fill_done;

    // Address split ignores the byte offset
    assign idx     = addr[`INDEX_W+1:2];
    assign tag     = addr[`ADDR_W-1:`INDEX_W+2];
    assign snp_idx = ccsnoopaddr[`INDEX_W+1:2];
    assign snp_tag = ccsnoopaddr[`ADDR_W-1:`INDEX_W+2];

    assign hit     = (state_mem[idx] != coherence_pkg::INVALID) && (tag_mem[idx] == tag);
    assign snp_hit = (state_mem[snp_idx] != coherence_pkg::INVALID)
                     && (tag_mem[snp_idx] == snp_tag);

    // A snoop on the same set wins this cycle, local access waits
    assign snoop_block = ccsnoop && (snp_idx == idx);

    // Reads hit in any valid state, writes need E or M
    assign local_ok = hit && !snoop_block
                      && (!wen || state_mem[idx] == coherence_pkg::EXCLUSIVE
                               || state_mem[idx] == coherence_pkg::MODIFIED);

    assign local_write  = (cstate == C_IDLE) && local_ok && wen;
    assign start_miss   = (cstate == C_IDLE) && (ren || wen) && !local_ok && !snoop_block;
    assign victim_dirty = (state_mem[idx] == coherence_pkg::MODIFIED) && (tag_mem[idx] != tag);
    assign fill_done    = (cstate == C_FETCH) && !dwait;

    // Busy drops on a hit, or in the cycle the fill arrives
    always_comb begin
        case (cstate)
            C_IDLE:  busy = (ren || wen) && !local_ok;
            C_FETCH: busy = dwait;
            default: busy = 1'b1;
        endcase
    end

    assign rdata = (cstate == C_FETCH) ? dload : data_mem[idx]; // Bypass fill data

    // Victim WB is dropped if a snoop already cleaned the line
    assign dWEN = (cstate == C_WB) && (state_mem[idx] == coherence_pkg::MODIFIED);
    assign dREN = (cstate == C_FETCH);
    assign daddr  = (cstate == C_WB) ? {tag_mem[idx], idx, 2'b00} : addr;
    assign dstore = data_mem[idx];                                 // Victim word

    always_comb begin
        if (dWEN)
            bus_op = coherence_pkg::BUS_WB;
        else if (dREN)
            bus_op = wen ? coherence_pkg::BUS_RDX : coherence_pkg::BUS_RD; // Upgrade uses RDX
        else
            bus_op = coherence_pkg::BUS_NONE;
    end

    // Control FSM and line states
    always_ff @(posedge CLK) begin
        if (reset) begin
            cstate <= C_IDLE;
            for (int i = 0; i < `L1_SETS; i++) begin
                state_mem[i] <= coherence_pkg::INVALID;
            end
        end else begin
            case (cstate)
                C_IDLE: begin
                    if (local_write)
                        state_mem[idx] <= coherence_pkg::MODIFIED;  // Silent E to M
                    else if (start_miss)
                        cstate <= victim_dirty ? C_WB : C_FETCH;
                end
                C_WB: begin
                    if (!dwait) begin
                        state_mem[idx] <= coherence_pkg::INVALID;   // Victim gone
                        cstate         <= C_FETCH;
                    end
                end
                C_FETCH: begin
                    if (!dwait) begin
                        if (wen)
                            state_mem[idx] <= coherence_pkg::MODIFIED;
                        else if (ccexclusive)
                            state_mem[idx] <= coherence_pkg::EXCLUSIVE;
                        else
                            state_mem[idx] <= coherence_pkg::SHARED;
                        cstate <= C_IDLE;
                    end
                end
                default: cstate <= C_IDLE;
            endcase
            // Snooped line drops last so it overrides
            if (ccsnoop && snp_hit)
                state_mem[snp_idx] <= ccinv ? coherence_pkg::INVALID : coherence_pkg::SHARED;
        end
    end

    // Tag and data arrays
    always_ff @(posedge CLK) begin
        if (local_write) begin
            data_mem[idx] <= wdata;
        end else if (fill_done) begin
            tag_mem[idx]  <= tag;
            data_mem[idx] <= wen ? wdata : dload;                  // Write merges into fill
        end
    end

    // Snoop reply is valid the cycle after the strobe
    always_ff @(posedge CLK) begin
        if (reset) begin
            ccsnoophit <= 1'b0;
            ccdirty    <= 1'b0;
        end else if (ccsnoop) begin
            ccsnoophit <= snp_hit;
            ccdirty    <= snp_hit && (state_mem[snp_idx] == coherence_pkg::MODIFIED);
        end
    end

    always_ff @(posedge CLK) begin
        if (ccsnoop)
            ccdata <= data_mem[snp_idx];
    end

endmodule

`default_nettype wire

/* logic/bus_pkg.sv */
// Bus controller and L2 types
`default_nettype none

package bus_pkg;

    // Controller phase
    typedef enum logic [2:0] {
        IDLE,
        GRANT,                                   // One cycle, latch owner
        SNOOP,                                   // Strobe, then sample reply
        TRANSFER,                                // Cache to cache
        READ_L2,
        WRITE_L2,
        COMPLETE                                 // Owner sees dwait low
    } bus_state_t;

    // Status coming back from the L2
    typedef enum logic [1:0] {
        L2_FREE,
        L2_BUSY,
        L2_ACCESS                                // Access done this cycle
    } l2_state_t;

endpackage

`default_nettype wire

/* logic/coherence_pkg.sv */
// Line state and bus op types
`default_nettype none

package coherence_pkg;

    // MESI state of one L1 line
    typedef enum logic [1:0] {
        INVALID,                                 // No copy
        SHARED,                                  // Clean, others may hold it
        EXCLUSIVE,                               // Clean, sole copy
        MODIFIED                                 // Dirty, sole copy
    } mesi_state_t;

    // Request a cache puts on the bus
    typedef enum logic [1:0] {
        BUS_NONE,                                // Nothing pending
        BUS_RD,                                  // Read to share
        BUS_RDX,                                 // Read for ownership
        BUS_WB                                   // Evicted dirty line to L2
    } bus_op_t;

endpackage

`default_nettype wire

/* include/coherence_macros.svh */
// Coherence subsystem sizes
`ifndef COHERENCE_MACROS_SVH
`define COHERENCE_MACROS_SVH

`define ADDR_W   32                              // Byte address width
`define WORD_W   32                              // One word per block
`define L1_SETS  4                               // Lines per L1
`define INDEX_W  2                               // Set index, address bits 3..2
`define NUM_CPUS 2                               // Cores on the bus

// Tag is what remains above index and byte offset
`define TAG_W    (`ADDR_W - `INDEX_W - 2)

`endif
